// File: Bender.yml
package:
  name: lsu_core

sources:
  - logic/isa_pkg.sv
  - logic/pipe_pkg.sv
  - logic/reg_file.sv
  - logic/decode_stage.sv
  - logic/execute_stage.sv
  - logic/mem_stage.sv
  - logic/lsu_core.sv
  - target: test
    files:
      - verification/tb_clock.sv
      - verification/lsu_core_tb.sv

// File: build.f
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/reg_file.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/mem_stage.sv
logic/lsu_core.sv
verification/tb_clock.sv
verification/lsu_core_tb.sv

// File: logic/decode_stage.sv
`timescale 1ns/1ps

module decode_stage #(
  parameter int NUM_REGS = 32
) (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic                             stall_i,
  input  logic                             inst_valid_i,
  input  logic [31:0]                      inst_i,
  output logic [$clog2(NUM_REGS)-1:0]      rs1_addr_o,
  output logic [$clog2(NUM_REGS)-1:0]      rs2_addr_o,
  input  logic [31:0]                      rs1_data_i,
  input  logic [31:0]                      rs2_data_i,
  input  logic [4:0]                       ex_fwd_rd_i,
  input  logic                             ex_fwd_we_i,
  input  logic                             ex_fwd_load_i,
  input  logic [31:0]                      ex_fwd_data_i,
  input  logic [4:0]                       mem_fwd_rd_i,
  input  logic                             mem_fwd_we_i,
  input  logic [31:0]                      mem_fwd_data_i,
  output logic                             bubble_o,
  output logic                             ex_valid_o,
  output logic [31:0]                      ex_op_a_o,
  output logic [31:0]                      ex_op_b_o,
  output logic                             ex_sub_o,
  output logic [31:0]                      ex_store_data_o,
  output logic [4:0]                       ex_rd_o,
  output logic                             ex_we_o,
  output pipe_pkg::mem_op_e                ex_mem_op_o,
  output pipe_pkg::mem_size_e              ex_mem_size_o,
  output logic                             ex_unsigned_o,
  output logic [pipe_pkg::EXC_WIDTH-1:0]   ex_exc_o
);

  localparam int RW = $clog2(NUM_REGS);

  isa_pkg::instr_u   inst;
  logic [4:0]        rs1;
  logic [4:0]        rs2;
  logic [4:0]        rd;
  logic [2:0]        funct3;
  logic [6:0]        funct7;
  logic [31:0]       imm;
  logic              legal;
  logic              uses_rs2;
  logic              imm_sel;
  logic              sub;
  logic              we;
  pipe_pkg::mem_op_e mem_op;
  logic              load_use;
  logic              take;
  logic [31:0]       rs1_val;
  logic [31:0]       rs2_val;

  assign inst       = inst_i;
  assign rs1        = inst.itype.rs1;
  assign rs2        = inst.stype.rs2;
  assign rd         = inst.itype.rd;
  assign funct3     = inst.itype.funct3;
  assign funct7     = inst.stype.imm_hi;
  assign rs1_addr_o = rs1[RW-1:0];
  assign rs2_addr_o = rs2[RW-1:0];

  // ############################
  // Instruction decode
  // ############################
  always_comb begin
    legal    = 1'b1;
    uses_rs2 = 1'b0;
    imm_sel  = 1'b1;
    sub      = 1'b0;
    we       = 1'b0;
    mem_op   = pipe_pkg::NONE;
    imm      = {{20{inst.itype.imm[11]}}, inst.itype.imm};
    case (inst.itype.opcode)
      isa_pkg::OP: begin
        uses_rs2 = 1'b1;
        imm_sel  = 1'b0;
        we       = 1'b1;
        sub      = (funct7 == isa_pkg::F7_SUB);
        legal    = (funct3 == isa_pkg::F3_ADD_SUB) &&
                   (funct7 == isa_pkg::F7_ADD || funct7 == isa_pkg::F7_SUB);
      end
      isa_pkg::OP_IMM: begin
        we    = 1'b1;
        legal = (funct3 == isa_pkg::F3_ADD_SUB);  // ADDI only.
      end
      isa_pkg::LOAD: begin
        we     = 1'b1;
        mem_op = pipe_pkg::LOAD;
        legal  = funct3 inside {isa_pkg::F3_BYTE, isa_pkg::F3_HALF, isa_pkg::F3_WORD,
                                isa_pkg::F3_BYTE_U, isa_pkg::F3_HALF_U};
      end
      isa_pkg::STORE: begin
        uses_rs2 = 1'b1;
        mem_op   = pipe_pkg::STORE;
        imm      = {{20{inst.stype.imm_hi[6]}}, inst.stype.imm_hi, inst.stype.imm_lo};
        legal    = funct3 inside {isa_pkg::F3_BYTE, isa_pkg::F3_HALF, isa_pkg::F3_WORD};
      end
      default: legal = 1'b0;
    endcase
    // Indices past a reduced register file.
    if (rs1 >= NUM_REGS || (uses_rs2 && rs2 >= NUM_REGS) || (we && rd >= NUM_REGS)) begin
      legal = 1'b0;
    end
    if (!legal) begin
      we       = 1'b0;
      uses_rs2 = 1'b0;
      mem_op   = pipe_pkg::NONE;
    end
    we = we && rd != 5'd0;  // x0 is never written.
  end

  // Load result is not ready until the memory stage.
  assign load_use = legal && ex_fwd_load_i && ex_fwd_we_i &&
                    (ex_fwd_rd_i == rs1 || (uses_rs2 && ex_fwd_rd_i == rs2));
  assign bubble_o = inst_valid_i && load_use;
  assign take     = inst_valid_i && !load_use;

  function automatic logic [31:0] operand(input logic [4:0] rs, input logic [31:0] rf_data);
    if (ex_fwd_we_i && ex_fwd_rd_i == rs) begin
      return ex_fwd_data_i;
    end else if (mem_fwd_we_i && mem_fwd_rd_i == rs) begin
      return mem_fwd_data_i;
    end
    return rf_data;
  endfunction

  always_comb begin
    rs1_val = operand(rs1, rs1_data_i);
    rs2_val = operand(rs2, rs2_data_i);
  end

  // ############################
  // ID/EX register
  // ############################
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ex_valid_o  <= 1'b0;
      ex_we_o     <= 1'b0;
      ex_mem_op_o <= pipe_pkg::NONE;
      ex_exc_o    <= '0;
    end else if (!stall_i) begin
      ex_valid_o  <= take;
      ex_we_o     <= take && we;
      ex_mem_op_o <= take ? mem_op : pipe_pkg::NONE;
      ex_exc_o    <= '0;
      ex_exc_o[pipe_pkg::EXC_ILLEGAL] <= take && !legal;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      ex_op_a_o       <= rs1_val;
      ex_op_b_o       <= imm_sel ? imm : rs2_val;
      ex_sub_o        <= sub;
      ex_store_data_o <= rs2_val;
      ex_rd_o         <= rd;
      ex_mem_size_o   <= pipe_pkg::mem_size_e'(funct3[1:0]);
      ex_unsigned_o   <= funct3[2];
    end
  end

endmodule

// File: logic/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           stall_i,
  input  logic                           ex_valid_i,
  input  logic [31:0]                    ex_op_a_i,
  input  logic [31:0]                    ex_op_b_i,
  input  logic                           ex_sub_i,
  input  logic [31:0]                    ex_store_data_i,
  input  logic [4:0]                     ex_rd_i,
  input  logic                           ex_we_i,
  input  pipe_pkg::mem_op_e              ex_mem_op_i,
  input  pipe_pkg::mem_size_e            ex_mem_size_i,
  input  logic                           ex_unsigned_i,
  input  logic [pipe_pkg::EXC_WIDTH-1:0] ex_exc_i,
  output logic [4:0]                     fwd_rd_o,
  output logic                           fwd_we_o,
  output logic                           fwd_load_o,
  output logic [31:0]                    fwd_data_o,
  output logic                           mem_valid_o,
  output logic [31:0]                    mem_result_o,
  output logic [31:0]                    mem_store_data_o,
  output logic [4:0]                     mem_rd_o,
  output logic                           mem_we_o,
  output pipe_pkg::mem_op_e              mem_op_o,
  output pipe_pkg::mem_size_e            mem_size_o,
  output logic                           mem_unsigned_o,
  output logic [pipe_pkg::EXC_WIDTH-1:0] mem_exc_o
);

  logic [31:0] alu;

  // ALU result or effective address.
  assign alu = ex_sub_i ? ex_op_a_i - ex_op_b_i : ex_op_a_i + ex_op_b_i;

  assign fwd_rd_o   = ex_rd_i;
  assign fwd_we_o   = ex_valid_i && ex_we_i;
  assign fwd_load_o = ex_valid_i && ex_mem_op_i == pipe_pkg::LOAD;
  assign fwd_data_o = alu;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      mem_valid_o <= 1'b0;
      mem_we_o    <= 1'b0;
      mem_op_o    <= pipe_pkg::NONE;
      mem_exc_o   <= '0;
    end else if (!stall_i) begin
      mem_valid_o <= ex_valid_i;
      mem_we_o    <= ex_valid_i && ex_we_i;
      mem_op_o    <= ex_valid_i ? ex_mem_op_i : pipe_pkg::NONE;
      mem_exc_o   <= ex_exc_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      mem_result_o     <= alu;
      mem_store_data_o <= ex_store_data_i;
      mem_rd_o         <= ex_rd_i;
      mem_size_o       <= ex_mem_size_i;
      mem_unsigned_o   <= ex_unsigned_i;
    end
  end

endmodule

// File: logic/isa_pkg.sv
package isa_pkg;

  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011
  } opcode_e;

  // Arithmetic and load/store size codes.
  parameter logic [2:0] F3_ADD_SUB = 3'b000;
  parameter logic [2:0] F3_BYTE    = 3'b000;
  parameter logic [2:0] F3_HALF    = 3'b001;
  parameter logic [2:0] F3_WORD    = 3'b010;
  parameter logic [2:0] F3_BYTE_U  = 3'b100;
  parameter logic [2:0] F3_HALF_U  = 3'b101;

  parameter logic [6:0] F7_ADD = 7'b0000000;
  parameter logic [6:0] F7_SUB = 7'b0100000;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } itype_t;

  typedef struct packed {
    logic [6:0] imm_hi;  // Also funct7 of R-type.
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } stype_t;

  typedef union packed {
    itype_t itype;
    stype_t stype;
  } instr_u;

endpackage

// File: logic/lsu_core.sv
`timescale 1ns/1ps

module lsu_core #(
  parameter int NUM_REGS = 32
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           inst_valid_i,
  input  logic [31:0]                    inst_i,
  output logic                           inst_ready_o,
  output logic                           dmem_req_o,
  output logic                           dmem_we_o,
  output logic [31:0]                    dmem_addr_o,
  output logic [3:0]                     dmem_be_o,
  output logic [31:0]                    dmem_wdata_o,
  input  logic [31:0]                    dmem_rdata_i,
  input  logic                           dmem_ack_i,
  input  logic                           dmem_err_i,
  output logic                           wb_valid_o,
  output logic [4:0]                     wb_rd_o,
  output logic                           wb_we_o,
  output logic [31:0]                    wb_data_o,
  output logic [pipe_pkg::EXC_WIDTH-1:0] wb_exc_o
);

  localparam int RW = $clog2(NUM_REGS);

  logic [RW-1:0]                  rs1_addr;
  logic [RW-1:0]                  rs2_addr;
  logic [31:0]                    rs1_data;
  logic [31:0]                    rs2_data;
  logic                           bubble;
  logic                           mem_stall;
  logic [4:0]                     ex_fwd_rd;
  logic                           ex_fwd_we;
  logic                           ex_fwd_load;
  logic [31:0]                    ex_fwd_data;
  logic [4:0]                     mem_fwd_rd;
  logic                           mem_fwd_we;
  logic [31:0]                    mem_fwd_data;
  logic                           ex_valid;
  logic [31:0]                    ex_op_a;
  logic [31:0]                    ex_op_b;
  logic                           ex_sub;
  logic [31:0]                    ex_store_data;
  logic [4:0]                     ex_rd;
  logic                           ex_we;
  pipe_pkg::mem_op_e              ex_mem_op;
  pipe_pkg::mem_size_e            ex_mem_size;
  logic                           ex_unsigned;
  logic [pipe_pkg::EXC_WIDTH-1:0] ex_exc;
  logic                           mem_valid;
  logic [31:0]                    mem_result;
  logic [31:0]                    mem_store_data;
  logic [4:0]                     mem_rd;
  logic                           mem_we;
  pipe_pkg::mem_op_e              mem_op;
  pipe_pkg::mem_size_e            mem_size;
  logic                           mem_unsigned;
  logic [pipe_pkg::EXC_WIDTH-1:0] mem_exc;

  assign inst_ready_o = !mem_stall && !bubble;

  reg_file #(.NUM_REGS(NUM_REGS)) u_reg_file (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .we_i       (wb_we_o),
    .waddr_i    (wb_rd_o[RW-1:0]),
    .wdata_i    (wb_data_o)
  );

  decode_stage #(.NUM_REGS(NUM_REGS)) u_decode (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .stall_i         (mem_stall),
    .inst_valid_i    (inst_valid_i),
    .inst_i          (inst_i),
    .rs1_addr_o      (rs1_addr),
    .rs2_addr_o      (rs2_addr),
    .rs1_data_i      (rs1_data),
    .rs2_data_i      (rs2_data),
    .ex_fwd_rd_i     (ex_fwd_rd),
    .ex_fwd_we_i     (ex_fwd_we),
    .ex_fwd_load_i   (ex_fwd_load),
    .ex_fwd_data_i   (ex_fwd_data),
    .mem_fwd_rd_i    (mem_fwd_rd),
    .mem_fwd_we_i    (mem_fwd_we),
    .mem_fwd_data_i  (mem_fwd_data),
    .bubble_o        (bubble),
    .ex_valid_o      (ex_valid),
    .ex_op_a_o       (ex_op_a),
    .ex_op_b_o       (ex_op_b),
    .ex_sub_o        (ex_sub),
    .ex_store_data_o (ex_store_data),
    .ex_rd_o         (ex_rd),
    .ex_we_o         (ex_we),
    .ex_mem_op_o     (ex_mem_op),
    .ex_mem_size_o   (ex_mem_size),
    .ex_unsigned_o   (ex_unsigned),
    .ex_exc_o        (ex_exc)
  );

  execute_stage u_execute (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .stall_i          (mem_stall),
    .ex_valid_i       (ex_valid),
    .ex_op_a_i        (ex_op_a),
    .ex_op_b_i        (ex_op_b),
    .ex_sub_i         (ex_sub),
    .ex_store_data_i  (ex_store_data),
    .ex_rd_i          (ex_rd),
    .ex_we_i          (ex_we),
    .ex_mem_op_i      (ex_mem_op),
    .ex_mem_size_i    (ex_mem_size),
    .ex_unsigned_i    (ex_unsigned),
    .ex_exc_i         (ex_exc),
    .fwd_rd_o         (ex_fwd_rd),
    .fwd_we_o         (ex_fwd_we),
    .fwd_load_o       (ex_fwd_load),
    .fwd_data_o       (ex_fwd_data),
    .mem_valid_o      (mem_valid),
    .mem_result_o     (mem_result),
    .mem_store_data_o (mem_store_data),
    .mem_rd_o         (mem_rd),
    .mem_we_o         (mem_we),
    .mem_op_o         (mem_op),
    .mem_size_o       (mem_size),
    .mem_unsigned_o   (mem_unsigned),
    .mem_exc_o        (mem_exc)
  );

  mem_stage u_mem (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .mem_valid_i      (mem_valid),
    .mem_result_i     (mem_result),
    .mem_store_data_i (mem_store_data),
    .mem_rd_i         (mem_rd),
    .mem_we_i         (mem_we),
    .mem_op_i         (mem_op),
    .mem_size_i       (mem_size),
    .mem_unsigned_i   (mem_unsigned),
    .mem_exc_i        (mem_exc),
    .dmem_req_o       (dmem_req_o),
    .dmem_we_o        (dmem_we_o),
    .dmem_addr_o      (dmem_addr_o),
    .dmem_be_o        (dmem_be_o),
    .dmem_wdata_o     (dmem_wdata_o),
    .dmem_rdata_i     (dmem_rdata_i),
    .dmem_ack_i       (dmem_ack_i),
    .dmem_err_i       (dmem_err_i),
    .mem_stall_o      (mem_stall),
    .fwd_rd_o         (mem_fwd_rd),
    .fwd_we_o         (mem_fwd_we),
    .fwd_data_o       (mem_fwd_data),
    .wb_valid_o       (wb_valid_o),
    .wb_rd_o          (wb_rd_o),
    .wb_we_o          (wb_we_o),
    .wb_data_o        (wb_data_o),
    .wb_exc_o         (wb_exc_o)
  );

endmodule

// File: logic/mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           mem_valid_i,
  input  logic [31:0]                    mem_result_i,
  input  logic [31:0]                    mem_store_data_i,
  input  logic [4:0]                     mem_rd_i,
  input  logic                           mem_we_i,
  input  pipe_pkg::mem_op_e              mem_op_i,
  input  pipe_pkg::mem_size_e            mem_size_i,
  input  logic                           mem_unsigned_i,
  input  logic [pipe_pkg::EXC_WIDTH-1:0] mem_exc_i,
  output logic                           dmem_req_o,
  output logic                           dmem_we_o,
  output logic [31:0]                    dmem_addr_o,
  output logic [3:0]                     dmem_be_o,
  output logic [31:0]                    dmem_wdata_o,
  input  logic [31:0]                    dmem_rdata_i,
  input  logic                           dmem_ack_i,
  input  logic                           dmem_err_i,
  output logic                           mem_stall_o,
  output logic [4:0]                     fwd_rd_o,
  output logic                           fwd_we_o,
  output logic [31:0]                    fwd_data_o,
  output logic                           wb_valid_o,
  output logic [4:0]                     wb_rd_o,
  output logic                           wb_we_o,
  output logic [31:0]                    wb_data_o,
  output logic [pipe_pkg::EXC_WIDTH-1:0] wb_exc_o
);

  logic                           is_load;
  logic                           is_store;
  logic                           misaligned;
  logic                           access;
  logic                           done;
  logic [31:0]                    lane;
  logic [31:0]                    load_data;
  logic [31:0]                    result;
  logic                           we;
  logic [pipe_pkg::EXC_WIDTH-1:0] exc;

  assign is_load  = mem_valid_i && mem_op_i == pipe_pkg::LOAD;
  assign is_store = mem_valid_i && mem_op_i == pipe_pkg::STORE;

  always_comb begin
    case (mem_size_i)
      pipe_pkg::HALF: misaligned = mem_result_i[0];
      pipe_pkg::WORD: misaligned = |mem_result_i[1:0];
      default:        misaligned = 1'b0;
    endcase
  end

  // ############################
  // Data memory request
  // ############################
  assign access      = (is_load || is_store) && !misaligned;
  assign done        = access && dmem_ack_i;
  assign dmem_req_o  = access;
  assign dmem_we_o   = is_store;
  assign dmem_addr_o = {mem_result_i[31:2], 2'b00};
  assign mem_stall_o = access && !dmem_ack_i;  // Held until ack.

  always_comb begin
    case (mem_size_i)
      pipe_pkg::BYTE: begin
        dmem_be_o    = 4'b0001 << mem_result_i[1:0];
        dmem_wdata_o = {4{mem_store_data_i[7:0]}};
      end
      pipe_pkg::HALF: begin
        dmem_be_o    = 4'b0011 << {mem_result_i[1], 1'b0};
        dmem_wdata_o = {2{mem_store_data_i[15:0]}};
      end
      default: begin
        dmem_be_o    = 4'b1111;
        dmem_wdata_o = mem_store_data_i;
      end
    endcase
  end

  // Move the addressed lane to bit 0.
  assign lane = dmem_rdata_i >> {mem_result_i[1:0], 3'b000};

  always_comb begin
    case (mem_size_i)
      pipe_pkg::BYTE: load_data = {{24{lane[7] && !mem_unsigned_i}}, lane[7:0]};
      pipe_pkg::HALF: load_data = {{16{lane[15] && !mem_unsigned_i}}, lane[15:0]};
      default:        load_data = lane;
    endcase
  end

  always_comb begin
    exc = mem_exc_i;
    exc[pipe_pkg::EXC_LOAD_MISALIGNED]  = is_load && misaligned;
    exc[pipe_pkg::EXC_STORE_MISALIGNED] = is_store && misaligned;
    exc[pipe_pkg::EXC_LOAD_FAULT]       = is_load && done && dmem_err_i;
    exc[pipe_pkg::EXC_STORE_FAULT]      = is_store && done && dmem_err_i;
  end

  assign result = (is_load && done) ? load_data : mem_result_i;
  assign we     = mem_valid_i && mem_we_i && exc == '0;

  assign fwd_rd_o   = mem_rd_i;
  assign fwd_we_o   = we;
  assign fwd_data_o = result;

  // ############################
  // Writeback register
  // ############################
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wb_valid_o <= 1'b0;
      wb_we_o    <= 1'b0;
      wb_exc_o   <= '0;
    end else begin
      wb_valid_o <= mem_valid_i && !mem_stall_o;  // Retire only once acked.
      wb_we_o    <= we && !mem_stall_o;
      if (!mem_stall_o) begin
        wb_exc_o <= exc;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!mem_stall_o) begin
      wb_rd_o   <= mem_rd_i;
      wb_data_o <= result;
    end
  end

endmodule

// File: logic/pipe_pkg.sv
package pipe_pkg;

  typedef enum logic [1:0] {
    NONE  = 2'd0,
    LOAD  = 2'd1,
    STORE = 2'd2
  } mem_op_e;

  // Matches the low two funct3 bits.
  typedef enum logic [1:0] {
    BYTE = 2'd0,
    HALF = 2'd1,
    WORD = 2'd2
  } mem_size_e;

  parameter int EXC_WIDTH = 5;

  // ############################
  // Exception flag positions
  // ############################
  parameter int EXC_ILLEGAL          = 0;
  parameter int EXC_LOAD_MISALIGNED  = 1;
  parameter int EXC_STORE_MISALIGNED = 2;
  parameter int EXC_LOAD_FAULT       = 3;
  parameter int EXC_STORE_FAULT      = 4;

endpackage

// File: logic/reg_file.sv
`timescale 1ns/1ps

module reg_file #(
  parameter int NUM_REGS = 32
) (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic [$clog2(NUM_REGS)-1:0] rs1_addr_i,
  input  logic [$clog2(NUM_REGS)-1:0] rs2_addr_i,
  output logic [31:0]                 rs1_data_o,
  output logic [31:0]                 rs2_data_o,
  input  logic                        we_i,
  input  logic [$clog2(NUM_REGS)-1:0] waddr_i,
  input  logic [31:0]                 wdata_i
);

  logic [31:0] regs [NUM_REGS];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // Same-cycle write is bypassed to the readers.
  assign rs1_data_o = (rs1_addr_i == '0) ? '0 :
                      (we_i && waddr_i == rs1_addr_i) ? wdata_i : regs[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 :
                      (we_i && waddr_i == rs2_addr_i) ? wdata_i : regs[rs2_addr_i];

endmodule

// File: verification/lsu_core_tb.sv
`timescale 1ns/1ps

module lsu_core_tb;

  localparam int N_ALU   = 60;
  localparam int N_MEM   = 60;
  localparam int N_LOAD  = 60;
  localparam int N_EXC   = 40;
  localparam int N_TOTAL = N_ALU + N_MEM + N_LOAD + N_EXC;
  localparam int LIMIT   = 20 * N_TOTAL + 200;

  logic        clk_i;
  logic        rst_n_i;
  logic        inst_valid_i;
  logic [31:0] inst_i;
  logic        inst_ready_o;
  logic        dmem_req_o;
  logic        dmem_we_o;
  logic [31:0] dmem_addr_o;
  logic [3:0]  dmem_be_o;
  logic [31:0] dmem_wdata_o;
  logic [31:0] dmem_rdata_i;
  logic        dmem_ack_i;
  logic        dmem_err_i;
  logic        wb_valid_o;
  logic [4:0]  wb_rd_o;
  logic        wb_we_o;
  logic [31:0] wb_data_o;
  logic [4:0]  wb_exc_o;

  integer      seed = 47;
  int          errors;
  int          tests_failed;
  int          cycles;
  int          accepted;
  int          retired;
  int          acks;
  int          exp_req;
  int          dly;
  logic        pend;
  logic [31:0] mem [256];
  logic [31:0] mmem [256];
  logic [31:0] regs [32];
  logic [42:0] expq [$];  // {exc, we, rd, data}
  logic [42:0] e;

  tb_clock #(.PERIOD(40)) u_clock (.clk_o(clk_i));

  lsu_core #(.NUM_REGS(32)) dut (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .inst_valid_i (inst_valid_i),
    .inst_i       (inst_i),
    .inst_ready_o (inst_ready_o),
    .dmem_req_o   (dmem_req_o),
    .dmem_we_o    (dmem_we_o),
    .dmem_addr_o  (dmem_addr_o),
    .dmem_be_o    (dmem_be_o),
    .dmem_wdata_o (dmem_wdata_o),
    .dmem_rdata_i (dmem_rdata_i),
    .dmem_ack_i   (dmem_ack_i),
    .dmem_err_i   (dmem_err_i),
    .wb_valid_o   (wb_valid_o),
    .wb_rd_o      (wb_rd_o),
    .wb_we_o      (wb_we_o),
    .wb_data_o    (wb_data_o),
    .wb_exc_o     (wb_exc_o)
  );

  function automatic int rnd(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic logic [31:0] alu_word(input logic [6:0] f7, input int rs2, input int rs1,
                                           input int rd);
    return {f7, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], 7'b0110011};
  endfunction

  function automatic logic [31:0] imm_word(input int imm, input int rs1, input logic [2:0] f3,
                                           input int rd, input logic [6:0] opc);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
  endfunction

  function automatic logic [31:0] store_word(input int imm, input int rs2, input int rs1,
                                             input logic [2:0] f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], 7'b0100011};
  endfunction

  // ##############################
  // Reference model
  // ##############################
  task automatic run_model(input logic [31:0] w);
    logic [6:0]  opc;
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] word;
    logic [4:0]  exc;
    logic        we;
    logic        mis;
    opc  = w[6:0];
    rd   = w[11:7];
    f3   = w[14:12];
    f7   = w[31:25];
    a    = regs[w[19:15]];
    b    = regs[w[24:20]];
    exc  = '0;
    we   = 1'b0;
    data = '0;
    addr = '0;
    mis  = 1'b0;
    if (opc == 7'b0110011 && f3 == 3'd0 && (f7 == 7'h00 || f7 == 7'h20)) begin
      data = (f7 == 7'h20) ? a - b : a + b;
      we   = 1'b1;
    end else if (opc == 7'b0010011 && f3 == 3'd0) begin
      data = a + {{20{w[31]}}, w[31:20]};
      we   = 1'b1;
    end else if (opc == 7'b0000011 && f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5}) begin
      addr = a + {{20{w[31]}}, w[31:20]};
      mis  = (f3[1:0] == 2'd1 && addr[0]) || (f3[1:0] == 2'd2 && addr[1:0] != 2'd0);
      if (mis) begin
        exc[1] = 1'b1;
      end else begin
        exp_req++;
        if (addr[31:2] >= 256) begin
          exc[3] = 1'b1;
        end else begin
          word = mmem[addr[9:2]];
          case (f3)
            3'd0: data = {{24{word[8*addr[1:0]+7]}}, word[8*addr[1:0] +: 8]};
            3'd4: data = {24'd0, word[8*addr[1:0] +: 8]};
            3'd1: data = {{16{word[16*addr[1]+15]}}, word[16*addr[1] +: 16]};
            3'd5: data = {16'd0, word[16*addr[1] +: 16]};
            default: data = word;
          endcase
          we = 1'b1;
        end
      end
    end else if (opc == 7'b0100011 && f3 inside {3'd0, 3'd1, 3'd2}) begin
      addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
      mis  = (f3 == 3'd1 && addr[0]) || (f3 == 3'd2 && addr[1:0] != 2'd0);
      if (mis) begin
        exc[2] = 1'b1;
      end else begin
        exp_req++;
        if (addr[31:2] >= 256) begin
          exc[4] = 1'b1;
        end else if (f3 == 3'd0) begin
          mmem[addr[9:2]][8*addr[1:0] +: 8] = b[7:0];
        end else if (f3 == 3'd1) begin
          mmem[addr[9:2]][16*addr[1] +: 16] = b[15:0];
        end else begin
          mmem[addr[9:2]] = b;
        end
      end
    end else begin
      exc[0] = 1'b1;  // Unsupported encoding.
    end
    we = we && rd != 5'd0;
    if (we) begin
      regs[rd] = data;
    end
    expq.push_back({exc, we, rd, data});
  endtask

  // Holds the word on the port until the DUT takes it.
  task automatic issue(input logic [31:0] w);
    logic taken;
    if (rnd(4) == 0) begin
      inst_valid_i = 1'b0;
      repeat (1 + rnd(3)) @(negedge clk_i);
    end
    taken        = 1'b0;
    inst_valid_i = 1'b1;
    inst_i       = w;
    while (!taken) begin
      #10;
      if (inst_ready_o) begin
        run_model(w);
        accepted++;
        taken = 1'b1;
      end
      @(negedge clk_i);
    end
  endtask

  task automatic drain();
    inst_valid_i = 1'b0;
    while (retired != accepted) @(negedge clk_i);
  endtask

  task automatic finish_test(input string name, input int errs_before);
    drain();
    if (expq.size() != 0) begin
      $display("%s: %0d expected results never retired", name, expq.size());
      errors++;
    end
    if (acks != exp_req) begin
      $display("%s: memory saw %0d requests, expected %0d", name, acks, exp_req);
      errors++;
    end
    if (errors == errs_before) begin
      $display("%s: PASS", name);
    end else begin
      $display("%s: FAIL (%0d errors)", name, errors - errs_before);
      tests_failed++;
    end
  endtask

  // ##############################
  // Data memory model
  // ##############################
  always @(negedge clk_i) begin
    if (!rst_n_i) begin
      dmem_ack_i = 1'b0;
      dmem_err_i = 1'b0;
      pend       = 1'b0;
    end else if (dmem_req_o) begin
      if (!pend) begin
        pend = 1'b1;
        dly  = rnd(4);
      end
      if (dly == 0) begin
        dmem_ack_i = 1'b1;
        pend       = 1'b0;
        acks++;
        dmem_err_i   = dmem_addr_o[31:2] >= 256;
        dmem_rdata_i = dmem_err_i ? 32'd0 : mem[dmem_addr_o[9:2]];
        if (dmem_we_o && !dmem_err_i) begin
          for (int i = 0; i < 4; i++) begin
            if (dmem_be_o[i]) mem[dmem_addr_o[9:2]][8*i +: 8] = dmem_wdata_o[8*i +: 8];
          end
        end
      end else begin
        dmem_ack_i = 1'b0;
        dly--;
      end
    end else begin
      dmem_ack_i = 1'b0;
      pend       = 1'b0;
    end
  end

  // Writeback monitor.
  always @(negedge clk_i) begin
    if (rst_n_i && wb_valid_o) begin
      retired++;
      if (expq.size() == 0) begin
        $display("Writeback seen with no instruction outstanding at %0t", $time);
        errors++;
      end else begin
        e = expq.pop_front();
        if (wb_we_o != e[37] || wb_exc_o != e[42:38] ||
            (e[37] && (wb_rd_o != e[36:32] || wb_data_o != e[31:0]))) begin
          $display("MISMATCH at %0t: rd %0d/%0d we %b/%b data %h/%h exc %b/%b (got/expected)",
                   $time, wb_rd_o, e[36:32], wb_we_o, e[37],
                   wb_data_o, e[31:0], wb_exc_o, e[42:38]);
          errors++;
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > LIMIT) begin
      $display("Timeout after %0d cycles, the pipeline stopped retiring", cycles);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  initial begin
    int eb;
    int sz;
    rst_n_i      = 1'b0;
    inst_valid_i = 1'b0;
    inst_i       = '0;
    dmem_rdata_i = '0;
    dmem_ack_i   = 1'b0;
    dmem_err_i   = 1'b0;
    for (int i = 0; i < 256; i++) begin
      mem[i]  = {~i[7:0], i[7:0], i[7:0] ^ 8'h5a, i[7:0] + 8'd17};
      mmem[i] = mem[i];
    end
    for (int i = 0; i < 32; i++) regs[i] = '0;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;

    // Test 1.
    eb = errors;
    @(negedge clk_i);
    #10;
    if (wb_valid_o || dmem_req_o || !inst_ready_o) begin
      $display("Reset state wrong: wb_valid=%b dmem_req=%b inst_ready=%b",
               wb_valid_o, dmem_req_o, inst_ready_o);
      errors++;
    end
    @(negedge clk_i);
    finish_test("test 1 reset state", eb);

    // Test 2 uses few registers so results chain.
    eb = errors;
    for (int n = 0; n < N_ALU; n++) begin
      case (rnd(3))
        0: issue(alu_word(7'h00, rnd(4), rnd(4), rnd(4)));
        1: issue(alu_word(7'h20, rnd(4), rnd(4), rnd(4)));
        default: issue(imm_word(rnd(4096), rnd(4), 3'd0, rnd(4), 7'b0010011));
      endcase
    end
    finish_test("test 2 alu and forwarding", eb);

    // Test 3 stays in sixteen words so loads see earlier stores.
    eb = errors;
    for (int n = 0; n < N_MEM; n++) begin
      sz = rnd(3);
      case (rnd(3))
        0: issue(imm_word(rnd(4096), 0, 3'd0, 1 + rnd(3), 7'b0010011));
        1: issue(store_word(rnd(16) * 4 + (sz == 0 ? rnd(4) : sz == 1 ? 2 * rnd(2) : 0),
                            1 + rnd(3), 0, sz[2:0]));
        default: issue(imm_word(rnd(16) * 4 + (sz == 0 ? rnd(4) : sz == 1 ? 2 * rnd(2) : 0),
                                0, {sz != 2 && rnd(2) == 1, sz[1:0]}, 1 + rnd(3),
                                7'b0000011));
      endcase
    end
    drain();
    for (int i = 0; i < 256; i++) begin
      if (mem[i] != mmem[i]) begin
        $display("MISMATCH at %0t: memory word %0d is %h, expected %h",
                 $time, i, mem[i], mmem[i]);
        errors++;
      end
    end
    finish_test("test 3 load/store sizes", eb);

    // Test 4.
    eb = errors;
    for (int n = 0; n < N_LOAD; n += 2) begin
      sz = 4 + rnd(2);
      issue(imm_word(rnd(64) * 4, 0, 3'd2, sz, 7'b0000011));
      if (rnd(3) == 0) begin
        issue(store_word(rnd(64) * 4, sz, 0, 3'd2));
      end else begin
        issue(alu_word(7'h00, rnd(6), sz, 1 + rnd(3)));
      end
    end
    finish_test("test 4 load-use and stall", eb);

    // Test 5.
    eb = errors;
    for (int n = 0; n < N_EXC; n++) begin
      case (rnd(6))
        0: issue(imm_word(rnd(64) * 4 + 1 + 2 * rnd(2), 0, 3'd1, 1 + rnd(3), 7'b0000011));
        1: issue(store_word(rnd(64) * 4 + 1 + 2 * rnd(2), 1, 0, 3'd1));
        2: issue(imm_word(rnd(64) * 4 + 1 + rnd(3), 0, 3'd2, 1 + rnd(3), 7'b0000011));
        3: issue(store_word(rnd(64) * 4 + 1 + rnd(3), 2, 0, 3'd2));
        4: begin
          if (rnd(2) == 0) issue(imm_word(1024 + rnd(256) * 4, 0, 3'd2, 1 + rnd(3), 7'b0000011));
          else issue(store_word(1024 + rnd(256) * 4, 3, 0, 3'd2));
        end
        default: begin
          if (rnd(2) == 0) issue(imm_word(rnd(64), 0, 3'd3, 1 + rnd(3), 7'b0000011));
          else issue(alu_word(7'h01, rnd(4), rnd(4), 1 + rnd(3)));
        end
      endcase
    end
    finish_test("test 5 exceptions", eb);

    $display("tests failed: %0d of 5, errors: %0d, instructions retired: %0d",
             tests_failed, errors, retired);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: verification/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD = 40
) (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

endmodule
